//--- cpu_pkg.sv
// CPU memory-side shared types
package cpu_pkg;

    parameter int data_w = 16;              // Data and address width

    typedef logic [3:0] reg_idx_t;          // Register file index

    ////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////

    // Execute to memory
    typedef struct packed {
        logic              call;
        logic              reg_write;
        logic              mem_write;
        logic              mem_read;
        logic              mem_to_reg;
        reg_idx_t          reg_rd;
        logic [data_w-1:0] alu_result;
        logic [data_w-1:0] store_data;      // PC during call
        logic              ret_future;
        logic              halt;
    } ex_mem_t;

    // Memory to writeback
    typedef struct packed {
        logic              reg_write;
        logic              mem_to_reg;
        reg_idx_t          reg_rd;
        logic [data_w-1:0] alu_result;      // Stack adjusted
        logic              ret_future;
        logic              halt;
    } mem_wb_t;

    // Fetch request from the instruction side
    typedef struct packed {
        logic              valid;
        logic              rw;              // Set means write, ignored here
        logic [data_w-1:0] addr;            // Byte address
        logic [data_w-1:0] data;
    } refill_req_t;

endpackage

//--- refill_if.sv
// Instruction refill link
`timescale 1ns/1ns

interface refill_if;

    logic                      req_valid;   // One cycle strobe
    logic [cpu_pkg::data_w-1:0] req_addr;   // Word address
    logic                      rdy;         // One cycle completion pulse
    logic [cpu_pkg::data_w-1:0] rdata;

    // Memory stage side
    modport requester (
        output req_valid,
        output req_addr,
        input  rdy,
        input  rdata
    );

    // Main memory side
    modport server (
        input  req_valid,
        input  req_addr,
        output rdy,
        output rdata
    );

endinterface

//--- pipe_reg.sv
// Generic pipeline register
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Valid bit is the only control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload follows every cycle
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

//--- data_memory.sv
// Word-addressed data RAM
`timescale 1ns/1ns

module data_memory #(
    parameter int words = 256
) (
    input  logic                       clk,
    input  logic [cpu_pkg::data_w-1:0] addr,
    input  logic                       re,
    input  logic                       we,
    input  logic [cpu_pkg::data_w-1:0] wdata,
    output logic [cpu_pkg::data_w-1:0] rdata
);

    localparam int idx_w = $clog2(words);

    logic [cpu_pkg::data_w-1:0] mem [words];
    logic [idx_w-1:0]           idx;

    assign idx = addr[idx_w-1:0];   // Upper address bits wrap

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    // Registered read, holds last word when idle
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[idx];
        end
    end

endmodule

//--- unified_mem.sv
// Fixed-latency main memory
`timescale 1ns/1ns

module unified_mem #(
    parameter int words   = 16,
    parameter int latency = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    refill_if.server    refill
);

    localparam int idx_w = $clog2(words);
    localparam int cnt_w = $clog2(latency + 1);

    logic [cpu_pkg::data_w-1:0] mem [words];
    logic                       busy;
    logic [cnt_w-1:0]           count;
    logic [idx_w-1:0]           addr_q;
    logic                       done;

    // Image loaded at start of simulation
    initial begin
        $readmemh("unified_mem.hex", mem);
    end

    assign done = busy && (count == '0);

    ////////////////////////////////////////
    // Request tracking
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            count      <= '0;
            refill.rdy <= 1'b0;
        end else begin
            refill.rdy <= 1'b0;                 // Pulse lasts one cycle
            if (busy) begin
                if (done) begin
                    busy       <= 1'b0;
                    refill.rdy <= 1'b1;
                end else begin
                    count <= count - cnt_w'(1);
                end
            end else if (refill.req_valid) begin
                busy  <= 1'b1;
                count <= cnt_w'(latency - 1);   // Counted from the accept edge
            end
        end
    end

    ////////////////////////////////////////
    // Address latch and read data
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!busy && refill.req_valid) begin
            addr_q <= refill.req_addr[idx_w-1:0];
        end
        if (done) begin
            refill.rdata <= mem[addr_q];
        end
    end

endmodule

//--- mem_stage.sv
// Memory access stage
`timescale 1ns/1ns

module mem_stage #(
    parameter int dmem_words = 256
) (
    input  logic                        clk,
    input  logic                        ex_valid,
    input  cpu_pkg::ex_mem_t            ex,
    input  cpu_pkg::refill_req_t        fetch_req,
    output logic                        wb_valid_d,
    output cpu_pkg::mem_wb_t            wb_next,
    output logic [cpu_pkg::data_w-1:0]  load_data,
    refill_if.requester                 refill
);

    logic [cpu_pkg::data_w-1:0] mem_addr;
    logic [cpu_pkg::data_w-1:0] mem_wdata;
    logic [cpu_pkg::data_w-1:0] result;
    logic                       mem_re;
    logic                       mem_we;

    ////////////////////////////////////////
    // Stack pointer adjust
    ////////////////////////////////////////

    always_comb begin
        if (ex.call) begin
            mem_addr  = ex.alu_result;
            mem_wdata = ex.store_data + 16'd2;  // Return past the call word
            result    = ex.alu_result - 16'd1;  // Push grows down
        end else if (ex.ret_future) begin
            mem_addr  = ex.alu_result + 16'd1;  // Pop from slot above
            mem_wdata = ex.store_data;
            result    = ex.alu_result + 16'd1;
        end else begin
            mem_addr  = ex.alu_result;
            mem_wdata = ex.store_data;
            result    = ex.alu_result;
        end
    end

    // Bubbles must not touch memory
    assign mem_re = ex_valid & ex.mem_read;
    assign mem_we = ex_valid & ex.mem_write;

    data_memory #(
        .words (dmem_words)
    ) u_dmem (
        .clk   (clk),
        .addr  (mem_addr),
        .re    (mem_re),
        .we    (mem_we),
        .wdata (mem_wdata),
        .rdata (load_data)
    );

    // Next stage payload
    assign wb_valid_d         = ex_valid;
    assign wb_next.reg_write  = ex.reg_write;
    assign wb_next.mem_to_reg = ex.mem_to_reg;
    assign wb_next.reg_rd     = ex.reg_rd;
    assign wb_next.alu_result = result;
    assign wb_next.ret_future = ex.ret_future;
    assign wb_next.halt       = ex.halt;

    ////////////////////////////////////////
    // Instruction refill request
    ////////////////////////////////////////

    // Reads only; memory is not writable from here
    assign refill.req_valid = fetch_req.valid & ~fetch_req.rw;
    assign refill.req_addr  = {1'b0, fetch_req.addr[cpu_pkg::data_w-1:1]};  // Byte to word

endmodule

//--- writeback_stage.sv
// Writeback stage
`timescale 1ns/1ns

module writeback_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid,
    input  cpu_pkg::mem_wb_t           next,
    input  logic [cpu_pkg::data_w-1:0] load_data,
    output logic                       wb_valid,
    output logic                       wb_reg_write,
    output cpu_pkg::reg_idx_t          wb_reg_rd,
    output logic [cpu_pkg::data_w-1:0] wb_data,
    output logic                       wb_ret,
    output logic                       halted
);

    cpu_pkg::mem_wb_t wb_q;
    logic             halt_q;

    // Mem/wb register
    pipe_reg #(
        .payload_t (cpu_pkg::mem_wb_t)
    ) u_mem_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (valid),
        .in_data   (next),
        .out_valid (wb_valid),
        .out_data  (wb_q)
    );

    // Sticky halt, set with the item that carries it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt_q <= 1'b0;
        end else if (valid && next.halt) begin
            halt_q <= 1'b1;
        end
    end

    assign halted       = halt_q;
    assign wb_reg_write = wb_valid & wb_q.reg_write & ~halt_q;  // Frozen after halt
    assign wb_reg_rd    = wb_q.reg_rd;
    assign wb_ret       = wb_valid & wb_q.ret_future;

    // Load word or adjusted ALU result
    assign wb_data = wb_q.mem_to_reg ? load_data : wb_q.alu_result;

endmodule

//--- mem_top.sv
// Memory-side pipeline top
`timescale 1ns/1ns

module mem_top #(
    parameter int dmem_words   = 256,
    parameter int umem_latency = 4,
    parameter int umem_words   = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // Execute stage results
    input  logic                       ex_valid,
    input  logic                       ex_call,
    input  logic                       ex_reg_write,
    input  logic                       ex_mem_write,
    input  logic                       ex_mem_read,
    input  logic                       ex_mem_to_reg,
    input  cpu_pkg::reg_idx_t          ex_reg_rd,
    input  logic [cpu_pkg::data_w-1:0] ex_alu_result,
    input  logic [cpu_pkg::data_w-1:0] ex_store_data,
    input  logic                       ex_ret_future,
    input  logic                       ex_halt,
    // Fetch refill request
    input  logic                       fetch_valid,
    input  logic                       fetch_rw,
    input  logic [cpu_pkg::data_w-1:0] fetch_addr,
    input  logic [cpu_pkg::data_w-1:0] fetch_data,
    // Writeback
    output logic                       wb_valid,
    output logic                       wb_reg_write,
    output cpu_pkg::reg_idx_t          wb_reg_rd,
    output logic [cpu_pkg::data_w-1:0] wb_data,
    output logic                       wb_ret,
    output logic                       halted,
    // Refill response
    output logic                       ifetch_rdy,
    output logic [cpu_pkg::data_w-1:0] ifetch_data
);

    cpu_pkg::ex_mem_t           ex_in;
    cpu_pkg::ex_mem_t           ex_q;
    logic                       ex_q_valid;
    cpu_pkg::refill_req_t       fetch_req;
    cpu_pkg::mem_wb_t           wb_next;
    logic                       wb_valid_d;
    logic [cpu_pkg::data_w-1:0] load_data;

    refill_if refill ();

    ////////////////////////////////////////
    // Input packing
    ////////////////////////////////////////

    assign ex_in = '{
        call:       ex_call,
        reg_write:  ex_reg_write,
        mem_write:  ex_mem_write,
        mem_read:   ex_mem_read,
        mem_to_reg: ex_mem_to_reg,
        reg_rd:     ex_reg_rd,
        alu_result: ex_alu_result,
        store_data: ex_store_data,
        ret_future: ex_ret_future,
        halt:       ex_halt
    };

    assign fetch_req = '{valid: fetch_valid, rw: fetch_rw, addr: fetch_addr, data: fetch_data};

    ////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////

    pipe_reg #(.payload_t(cpu_pkg::ex_mem_t)) u_ex_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ex_valid),
        .in_data   (ex_in),
        .out_valid (ex_q_valid),
        .out_data  (ex_q)
    );

    mem_stage #(.dmem_words(dmem_words)) u_mem (
        .clk        (clk),
        .ex_valid   (ex_q_valid),
        .ex         (ex_q),
        .fetch_req  (fetch_req),
        .wb_valid_d (wb_valid_d),
        .wb_next    (wb_next),
        .load_data  (load_data),
        .refill     (refill.requester)
    );

    writeback_stage u_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (wb_valid_d),
        .next         (wb_next),
        .load_data    (load_data),
        .wb_valid     (wb_valid),
        .wb_reg_write (wb_reg_write),
        .wb_reg_rd    (wb_reg_rd),
        .wb_data      (wb_data),
        .wb_ret       (wb_ret),
        .halted       (halted)
    );

    // Main memory beside the pipeline
    unified_mem #(
        .words   (umem_words),
        .latency (umem_latency)
    ) u_umem (
        .clk    (clk),
        .rst_n  (rst_n),
        .refill (refill.server)
    );

    assign ifetch_rdy  = refill.rdy;
    assign ifetch_data = refill.rdata;

endmodule

//--- tb_clock.sv
// Testbench clock source
`timescale 1ns/1ns

module tb_clock #(
    parameter int period = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

//--- mem_top_sva.sv
// Memory-side pipeline assertions
`timescale 1ns/1ns

module mem_top_sva (
    input logic clk,
    input logic rst_n,
    input logic ex_valid,
    input logic wb_valid,
    input logic wb_reg_write,
    input logic halted,
    input logic ifetch_rdy
);

    // Refill completion is a single-cycle pulse
    rdy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ifetch_rdy |=> !ifetch_rdy)
        else $error("ifetch_rdy held high for two cycles");

    // Two register stages from ex input to writeback
    wb_follows_ex: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid == $past(ex_valid, 2))
        else $error("wb_valid does not follow ex_valid by 2 cycles");

    no_write_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !wb_reg_write)
        else $error("register write seen while halted");

endmodule

bind mem_top mem_top_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid     (ex_valid),
    .wb_valid     (wb_valid),
    .wb_reg_write (wb_reg_write),
    .halted       (halted),
    .ifetch_rdy   (ifetch_rdy)
);

//--- mem_top_tb.sv
// Memory-side pipeline testbench
`timescale 1ns/1ns

module mem_top_tb;

    localparam int lat        = 4;
    localparam int max_cycles = 400;    // Tests take about 40 cycles

    logic                       clk;
    logic                       rst_n;
    logic                       ex_valid;
    logic                       ex_call;
    logic                       ex_reg_write;
    logic                       ex_mem_write;
    logic                       ex_mem_read;
    logic                       ex_mem_to_reg;
    cpu_pkg::reg_idx_t          ex_reg_rd;
    logic [cpu_pkg::data_w-1:0] ex_alu_result;
    logic [cpu_pkg::data_w-1:0] ex_store_data;
    logic                       ex_ret_future;
    logic                       ex_halt;
    logic                       fetch_valid;
    logic                       fetch_rw;
    logic [cpu_pkg::data_w-1:0] fetch_addr;
    logic [cpu_pkg::data_w-1:0] fetch_data;
    logic                       wb_valid;
    logic                       wb_reg_write;
    cpu_pkg::reg_idx_t          wb_reg_rd;
    logic [cpu_pkg::data_w-1:0] wb_data;
    logic                       wb_ret;
    logic                       halted;
    logic                       ifetch_rdy;
    logic [cpu_pkg::data_w-1:0] ifetch_data;
    int                         cycles = 0;

    tb_clock #(.period(100)) u_clk (.clk(clk));

    mem_top #(.umem_latency(lat)) uut (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("Timeout: tests did not finish within %0d cycles", max_cycles);
            $display("SIMULATION FAILED");
            $fatal(1, "Run stopped by cycle limit");
        end
    end

    ////////////////////////////////////////
    // Drive and compare helpers
    ////////////////////////////////////////

    task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic send_ex(input logic call, input logic ret, input logic halt,
                           input logic mwr, input logic mrd, input logic m2r,
                           input logic rwr, input cpu_pkg::reg_idx_t rd,
                           input logic [15:0] alu, input logic [15:0] sd);
        ex_valid      = 1'b1;
        ex_call       = call;
        ex_ret_future = ret;
        ex_halt       = halt;
        ex_mem_write  = mwr;
        ex_mem_read   = mrd;
        ex_mem_to_reg = m2r;
        ex_reg_write  = rwr;
        ex_reg_rd     = rd;
        ex_alu_result = alu;
        ex_store_data = sd;
    endtask

    task automatic drop_valid();
        ex_valid    = 1'b0;
        fetch_valid = 1'b0;
    endtask

    task automatic check_writeback(input logic [15:0] data, input cpu_pkg::reg_idx_t rd,
                                   input logic we);
        check("wb_valid", 16'(wb_valid), 16'h1);
        check("wb_data", wb_data, data);
        check("wb_reg_rd", 16'(wb_reg_rd), 16'(rd));
        check("wb_reg_write", 16'(wb_reg_write), 16'(we));
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic store_load();
        logic [15:0] addr;
        logic [15:0] data;
        addr = 16'($urandom_range(255, 0));
        data = 16'($urandom);
        send_ex(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'h0, addr, data);
        @(negedge clk);
        send_ex(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 4'h3, addr, 16'h0);
        @(negedge clk);
        drop_valid();
        @(negedge clk);
        check_writeback(data, 4'h3, 1'b1);      // Load result
    endtask

    task automatic alu_pass();
        logic [15:0]       alu;
        cpu_pkg::reg_idx_t rd;
        alu = 16'($urandom);
        rd  = 4'($urandom);
        send_ex(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, rd, alu, 16'h0);
        @(negedge clk);
        drop_valid();
        @(negedge clk);
        check_writeback(alu, rd, 1'b1);
    endtask

    task automatic call_return();
        logic [15:0] sp;
        logic [15:0] pc;
        sp = 16'($urandom_range(255, 16));
        pc = 16'($urandom);
        send_ex(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 4'hf, sp, pc);  // Push
        @(negedge clk);
        send_ex(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 4'hd, sp - 16'd1, 16'h0);
        @(negedge clk);
        check_writeback(sp - 16'd1, 4'hf, 1'b1);
        check("wb_ret on call", 16'(wb_ret), 16'h0);
        // Same pop again, this time keeping the new stack pointer
        send_ex(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 4'hf, sp - 16'd1, 16'h0);
        @(negedge clk);
        check_writeback(pc + 16'd2, 4'hd, 1'b1);
        check("wb_ret", 16'(wb_ret), 16'h1);
        drop_valid();
        @(negedge clk);
        check_writeback(sp, 4'hf, 1'b1);
    endtask

    task automatic refill_read();
        logic [15:0] baddr;
        logic [15:0] widx;
        int          n;
        baddr       = 16'($urandom);
        widx        = (baddr >> 1) & 16'h000f;  // Image holds 16 words
        fetch_valid = 1'b1;
        fetch_rw    = 1'b0;
        fetch_addr  = baddr;
        fetch_data  = 16'($urandom);
        @(negedge clk);
        fetch_valid = 1'b0;
        n = 0;
        while (!ifetch_rdy && n < 2 * lat) begin
            @(negedge clk);
            n++;
        end
        check("ifetch_rdy", 16'(ifetch_rdy), 16'h1);
        check("refill latency", 16'(n), 16'(lat));
        check("ifetch_data", ifetch_data, 16'ha5c0 + widx * 16'h0101);
    endtask

    task automatic write_ignored();
        fetch_valid = 1'b1;
        fetch_rw    = 1'b1;
        fetch_addr  = 16'($urandom);
        @(negedge clk);
        fetch_valid = 1'b0;
        repeat (2 * lat) begin
            @(negedge clk);
            check("ifetch_rdy on write", 16'(ifetch_rdy), 16'h0);
        end
        fetch_rw = 1'b0;
    endtask

    task automatic back_to_back();
        logic [15:0] vals [4];
        for (int i = 0; i < 4; i++) begin
            vals[i] = 16'($urandom);
            send_ex(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 4'(i + 1), vals[i], 16'h0);
            if (i >= 2) begin
                check_writeback(vals[i-2], 4'(i - 1), 1'b1);
            end
            @(negedge clk);
        end
        drop_valid();
        check_writeback(vals[2], 4'h3, 1'b1);
        @(negedge clk);
        check_writeback(vals[3], 4'h4, 1'b1);
    endtask

    task automatic halt_freeze();
        logic [15:0] v0;
        logic [15:0] v1;
        v0 = 16'($urandom);
        v1 = 16'($urandom);
        send_ex(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 4'h5, v0, 16'h0);
        @(negedge clk);
        send_ex(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 4'h6, v1, 16'h0);
        @(negedge clk);
        drop_valid();
        check("halted", 16'(halted), 16'h1);
        check_writeback(v0, 4'h5, 1'b0);
        @(negedge clk);
        check_writeback(v1, 4'h6, 1'b0);    // Write suppressed
    endtask

    initial begin
        void'($urandom(32'hed7f));
        rst_n = 1'b0;
        send_ex(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 16'h0, 16'h0);
        drop_valid();
        fetch_rw   = 1'b0;
        fetch_addr = 16'h0;
        fetch_data = 16'h0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check("wb_valid after reset", 16'(wb_valid), 16'h0);
        check("wb_reg_write after reset", 16'(wb_reg_write), 16'h0);
        check("ifetch_rdy after reset", 16'(ifetch_rdy), 16'h0);
        check("halted after reset", 16'(halted), 16'h0);
        store_load();
        alu_pass();
        call_return();
        refill_read();
        refill_read();
        write_ignored();
        back_to_back();
        halt_freeze();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- unified_mem.hex
// One 16-bit word per line, word addresses 0 to 15 in order
// Word value is a5c0 + address * 0101
a5c0
a6c1
a7c2
a8c3
a9c4
aac5
abc6
acc7
adc8
aec9
afca
b0cb
b1cc
b2cd
b3ce
b4cf

//--- list.f
cpu_pkg.sv
refill_if.sv
pipe_reg.sv
data_memory.sv
unified_mem.sv
mem_stage.sv
writeback_stage.sv
mem_top.sv
tb_clock.sv
mem_top_sva.sv
mem_top_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory-side testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f --top-module mem_top_tb -o sim_mem_top; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_top)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
